// ==== common/fetch_pkg.sv ====
// shared types, selector encodings and default sizes for the fetch subsystem, imported by the RTL
package fetch_pkg;

  // ------------------------------
  // widths with a meaning
  // ------------------------------
  typedef logic [31:0] addr_t;       // byte address
  typedef logic [31:0] word_t;       // instruction or data word
  typedef logic [23:0] trap_base_t;  // upper bits of the trap vector base
  typedef logic [4:0]  irq_id_t;     // vectored interrupt number

  // next pc source, driven by the controller together with pc_set
  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd1,  // target from decode
    PC_BRANCH    = 3'd2,  // target from execute
    PC_EXCEPTION = 3'd3,  // trap address, see exc_sel_e
    PC_MRET      = 3'd4,
    PC_DRET      = 3'd5,
    PC_FENCEI    = 3'd6   // refetch the instruction after the fence
  } pc_sel_e;

  // trap address source
  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION = 2'd0,  // synchronous trap, base only
    EXC_PC_IRQ       = 2'd1,  // vectored interrupt
    EXC_PC_DBD       = 2'd2,  // debug halt
    EXC_PC_DBE       = 2'd3   // exception while in debug
  } exc_sel_e;

  // ------------------------------
  // default sizes
  // ------------------------------
  localparam int FIFO_DEPTH_DEF = 2;    // prefetch entries
  localparam int MEM_WORDS_DEF  = 256;  // instruction memory words

endpackage

// ==== fetch/if_stage.sv ====
// fetch stage: picks the next pc on a redirect and registers fetched words into the IF/ID stage
`timescale 1ns/1ns
module if_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  fetch_pkg::addr_t     boot_addr_i,
  input  fetch_pkg::addr_t     dm_halt_addr_i,
  input  fetch_pkg::addr_t     dm_exception_addr_i,
  input  fetch_pkg::addr_t     mepc_i,
  input  fetch_pkg::addr_t     depc_i,
  input  fetch_pkg::addr_t     jump_target_id_i,
  input  fetch_pkg::addr_t     jump_target_ex_i,
  input  fetch_pkg::trap_base_t trap_base_i,
  input  fetch_pkg::irq_id_t   irq_id_i,
  input  logic                 pc_set_i,             // redirect this cycle
  input  fetch_pkg::pc_sel_e   pc_sel_i,
  input  fetch_pkg::exc_sel_e  exc_sel_i,
  input  logic                 req_i,                // fetch enable
  input  logic                 halt_if_i,
  input  logic                 id_ready_i,
  input  logic                 clear_instr_valid_i,
  input  logic                 fetch_valid_i,        // head of prefetch fifo
  input  fetch_pkg::word_t     fetch_rdata_i,
  input  fetch_pkg::addr_t     fetch_addr_i,
  output logic                 fetch_ready_o,        // pops the head
  output logic                 branch_o,
  output fetch_pkg::addr_t     branch_addr_o,
  output logic                 instr_valid_id_o,
  output fetch_pkg::word_t     instr_rdata_id_o,
  output fetch_pkg::addr_t     pc_id_o,
  output fetch_pkg::addr_t     pc_if_o,
  output logic                 csr_mtvec_init_o,
  output logic                 perf_imiss_o
);
  import fetch_pkg::*;

  addr_t exc_pc;        // trap handler address
  logic  fetch_accept;  // head moves into IF/ID this edge

  // ------------------------------
  // trap and redirect addresses
  // ------------------------------
  always_comb begin
    case (exc_sel_i)
      EXC_PC_EXCEPTION: exc_pc = {trap_base_i, 8'h00};                  // all traps share base
      EXC_PC_IRQ:       exc_pc = {trap_base_i, 1'b0, irq_id_i, 2'b00};  // one word per irq
      EXC_PC_DBD:       exc_pc = {dm_halt_addr_i[31:2], 2'b00};
      EXC_PC_DBE:       exc_pc = {dm_exception_addr_i[31:2], 2'b00};
      default:          exc_pc = {trap_base_i, 8'h00};
    endcase
  end

  always_comb begin
    case (pc_sel_i)
      PC_BOOT:      branch_addr_o = {boot_addr_i[31:2], 2'b00};
      PC_JUMP:      branch_addr_o = jump_target_id_i;
      PC_BRANCH:    branch_addr_o = jump_target_ex_i;
      PC_EXCEPTION: branch_addr_o = exc_pc;
      PC_MRET:      branch_addr_o = mepc_i;
      PC_DRET:      branch_addr_o = depc_i;
      PC_FENCEI:    branch_addr_o = pc_id_o + 32'd4;  // word after the fence in decode
      default:      branch_addr_o = {boot_addr_i[31:2], 2'b00};
    endcase
  end

  assign branch_o         = pc_set_i;
  assign csr_mtvec_init_o = pc_set_i & (pc_sel_i == PC_BOOT);  // mtvec init on boot
  assign perf_imiss_o     = ~fetch_valid_i & ~pc_set_i;

  // ------------------------------
  // fetch control
  // ------------------------------
  // a redirect wins over the word at the head, it belongs to the old path
  assign fetch_accept  = fetch_valid_i & req_i & id_ready_i & ~halt_if_i & ~pc_set_i;
  assign fetch_ready_o = fetch_accept;
  assign pc_if_o       = fetch_addr_i;

  // IF/ID register, holds while decode stalls
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_id_o <= 1'b0;
      pc_id_o          <= '0;
    end else if (fetch_accept) begin
      instr_valid_id_o <= 1'b1;
      pc_id_o          <= fetch_addr_i;
    end else if (clear_instr_valid_i) begin
      instr_valid_id_o <= 1'b0;  // pc kept for fence.i
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_accept) instr_rdata_id_o <= fetch_rdata_i;
  end

endmodule

// ==== fetch/prefetch_buffer.sv ====
// prefetch buffer: Wishbone read master that keeps a small FIFO of sequential instruction words
`timescale 1ns/1ns
module prefetch_buffer #(
  parameter int FIFO_DEPTH = fetch_pkg::FIFO_DEPTH_DEF
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             req_i,          // fetch enable
  input  logic             branch_i,       // flush and restart
  input  fetch_pkg::addr_t branch_addr_i,
  input  logic             fetch_ready_i,
  output logic             fetch_valid_o,
  output fetch_pkg::word_t fetch_rdata_o,
  output fetch_pkg::addr_t fetch_addr_o,
  output logic             wb_cyc_o,
  output logic             wb_stb_o,
  output fetch_pkg::addr_t wb_adr_o,
  input  fetch_pkg::word_t wb_dat_i,
  input  logic             wb_ack_i,
  output logic             busy_o
);
  import fetch_pkg::*;

  localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CW = $clog2(FIFO_DEPTH + 1);

  typedef enum logic [1:0] {
    IDLE,      // no bus cycle
    WAIT_ACK,  // read in flight, data goes to the fifo
    DISCARD    // read from before a branch, data dropped
  } state_e;

  state_e         state;
  addr_t          next_addr;            // address of the next read to issue
  addr_t          adr_q;                // address of the read in flight
  word_t          instr_q [FIFO_DEPTH];
  addr_t          addr_q  [FIFO_DEPTH];
  logic [PW-1:0]  rptr, wptr;
  logic [CW-1:0]  cnt;
  logic           issue, push, pop;

  // only IDLE starts a read, so cnt already counts the one in flight
  assign issue = (state == IDLE) & req_i & ~branch_i & (cnt < CW'(FIFO_DEPTH));
  assign push  = (state == WAIT_ACK) & wb_ack_i & ~branch_i;
  assign pop   = fetch_ready_i & fetch_valid_o;

  // ------------------------------
  // bus side
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      next_addr <= '0;
    end else begin
      case (state)
        IDLE:     if (issue) state <= WAIT_ACK;
        WAIT_ACK: if (wb_ack_i) state <= IDLE;
                  else if (branch_i) state <= DISCARD;  // finish the cycle, drop its word
        DISCARD:  if (wb_ack_i) state <= IDLE;
        default:  state <= IDLE;
      endcase
      if (branch_i) next_addr <= branch_addr_i;
      else if (issue) next_addr <= next_addr + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) adr_q <= next_addr;  // steady until ack
  end

  assign wb_cyc_o = (state != IDLE);
  assign wb_stb_o = (state != IDLE);
  assign wb_adr_o = adr_q;
  assign busy_o   = (state != IDLE);

  // ------------------------------
  // fifo
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rptr <= '0;
      wptr <= '0;
      cnt  <= '0;
    end else if (branch_i) begin
      rptr <= '0;  // flush
      wptr <= '0;
      cnt  <= '0;
    end else begin
      if (push) wptr <= (wptr == PW'(FIFO_DEPTH - 1)) ? '0 : wptr + 1'b1;
      if (pop)  rptr <= (rptr == PW'(FIFO_DEPTH - 1)) ? '0 : rptr + 1'b1;
      cnt <= cnt + CW'(push) - CW'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      instr_q[wptr] <= wb_dat_i;
      addr_q[wptr]  <= adr_q;
    end
  end

  assign fetch_valid_o = (cnt != '0);
  assign fetch_rdata_o = instr_q[rptr];
  assign fetch_addr_o  = addr_q[rptr];

endmodule

// ==== logic/wb_arbiter.sv ====
// two-master Wishbone classic arbiter, round robin, grant held until the master drops cyc
`timescale 1ns/1ns
module wb_arbiter (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             m0_cyc_i,
  input  logic             m0_stb_i,
  input  logic             m0_we_i,
  input  fetch_pkg::addr_t m0_adr_i,
  input  fetch_pkg::word_t m0_dat_i,
  output fetch_pkg::word_t m0_dat_o,
  output logic             m0_ack_o,
  input  logic             m1_cyc_i,
  input  logic             m1_stb_i,
  input  logic             m1_we_i,
  input  fetch_pkg::addr_t m1_adr_i,
  input  fetch_pkg::word_t m1_dat_i,
  output fetch_pkg::word_t m1_dat_o,
  output logic             m1_ack_o,
  output logic             s_cyc_o,
  output logic             s_stb_o,
  output logic             s_we_o,
  output fetch_pkg::addr_t s_adr_o,
  output fetch_pkg::word_t s_dat_o,
  input  fetch_pkg::word_t s_dat_i,
  input  logic             s_ack_i
);

  logic busy;  // a grant is active
  logic gnt;   // granted master, doubles as last served
  logic own0, own1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      gnt  <= 1'b1;  // m0 first after reset
    end else if (!busy) begin
      if (m0_cyc_i && m1_cyc_i) begin
        busy <= 1'b1;
        gnt  <= ~gnt;  // the one not served last
      end else if (m0_cyc_i || m1_cyc_i) begin
        busy <= 1'b1;
        gnt  <= m1_cyc_i;
      end
    end else if (!(gnt ? m1_cyc_i : m0_cyc_i)) begin
      busy <= 1'b0;  // owner finished
    end
  end

  assign own0 = busy & ~gnt;
  assign own1 = busy & gnt;

  // request path, muxed by owner
  assign s_cyc_o = own1 ? m1_cyc_i : own0 & m0_cyc_i;
  assign s_stb_o = own1 ? m1_stb_i : own0 & m0_stb_i;
  assign s_we_o  = own1 ? m1_we_i  : own0 & m0_we_i;
  assign s_adr_o = own1 ? m1_adr_i : m0_adr_i;
  assign s_dat_o = own1 ? m1_dat_i : m0_dat_i;

  // response path, only the owner sees it
  assign m0_ack_o = own0 & s_ack_i;
  assign m1_ack_o = own1 & s_ack_i;
  assign m0_dat_o = own0 ? s_dat_i : '0;
  assign m1_dat_o = own1 ? s_dat_i : '0;

endmodule

// ==== logic/load_port.sv ====
// load port: turns a request pulse into one Wishbone classic read or write with a done pulse
`timescale 1ns/1ns
module load_port (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             req_i,    // ignored while busy
  input  logic             we_i,
  input  fetch_pkg::addr_t addr_i,
  input  fetch_pkg::word_t wdata_i,
  output logic             done_o,   // one cycle, with rdata_o
  output fetch_pkg::word_t rdata_o,
  output logic             wb_cyc_o,
  output logic             wb_stb_o,
  output logic             wb_we_o,
  output fetch_pkg::addr_t wb_adr_o,
  output fetch_pkg::word_t wb_dat_o,
  input  fetch_pkg::word_t wb_dat_i,
  input  logic             wb_ack_i
);
  import fetch_pkg::*;

  logic  busy;
  logic  we_q;
  addr_t adr_q;
  word_t dat_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy   <= 1'b0;
      done_o <= 1'b0;
    end else begin
      done_o <= busy & wb_ack_i;
      if (!busy) busy <= req_i;
      else if (wb_ack_i) busy <= 1'b0;  // drop cyc after ack
    end
  end

  always_ff @(posedge clk) begin
    if (!busy && req_i) begin
      we_q  <= we_i;     // request held for the whole cycle
      adr_q <= addr_i;
      dat_q <= wdata_i;
    end
    if (busy && wb_ack_i) rdata_o <= wb_dat_i;
  end

  assign wb_cyc_o = busy;
  assign wb_stb_o = busy;
  assign wb_we_o  = we_q;
  assign wb_adr_o = adr_q;
  assign wb_dat_o = dat_q;

endmodule

// ==== logic/wb_sram.sv ====
// word-addressed Wishbone classic memory, single-cycle registered acknowledge
`timescale 1ns/1ns
module wb_sram #(
  parameter int MEM_WORDS = fetch_pkg::MEM_WORDS_DEF
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             wb_cyc_i,
  input  logic             wb_stb_i,
  input  logic             wb_we_i,
  input  fetch_pkg::addr_t wb_adr_i,
  input  fetch_pkg::word_t wb_dat_i,
  output fetch_pkg::word_t wb_dat_o,
  output logic             wb_ack_o
);
  import fetch_pkg::*;

  localparam int AW = $clog2(MEM_WORDS);

  word_t         mem [MEM_WORDS];
  logic [AW-1:0] idx;
  logic          access;  // first cycle of a transfer

  assign idx    = wb_adr_i[AW+1:2];  // byte address to word index
  assign access = wb_cyc_i & wb_stb_i & ~wb_ack_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) wb_ack_o <= 1'b0;
    else        wb_ack_o <= access;  // high for one cycle only
  end

  always_ff @(posedge clk) begin
    if (access && wb_we_i) mem[idx] <= wb_dat_i;
    if (access)            wb_dat_o <= mem[idx];
  end

endmodule

// ==== logic/fetch_top.sv ====
// fetch subsystem top: fetch stage, prefetch buffer and load port sharing one memory
`timescale 1ns/1ns
module fetch_top #(
  parameter int FIFO_DEPTH = fetch_pkg::FIFO_DEPTH_DEF,
  parameter int MEM_WORDS  = fetch_pkg::MEM_WORDS_DEF
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  fetch_pkg::addr_t      boot_addr_i,
  input  fetch_pkg::addr_t      dm_halt_addr_i,
  input  fetch_pkg::addr_t      dm_exception_addr_i,
  input  fetch_pkg::addr_t      mepc_i,
  input  fetch_pkg::addr_t      depc_i,
  input  fetch_pkg::addr_t      jump_target_id_i,
  input  fetch_pkg::addr_t      jump_target_ex_i,
  input  fetch_pkg::trap_base_t trap_base_i,
  input  fetch_pkg::irq_id_t    irq_id_i,
  input  logic                  pc_set_i,
  input  fetch_pkg::pc_sel_e    pc_sel_i,
  input  fetch_pkg::exc_sel_e   exc_sel_i,
  input  logic                  req_i,
  input  logic                  halt_if_i,
  input  logic                  id_ready_i,
  input  logic                  clear_instr_valid_i,
  output logic                  instr_valid_id_o,
  output fetch_pkg::word_t      instr_rdata_id_o,
  output fetch_pkg::addr_t      pc_id_o,
  output fetch_pkg::addr_t      pc_if_o,
  output logic                  csr_mtvec_init_o,
  output logic                  perf_imiss_o,
  output logic                  if_busy_o,      // prefetch read in flight
  input  logic                  lp_req_i,       // load port
  input  logic                  lp_we_i,
  input  fetch_pkg::addr_t      lp_addr_i,
  input  fetch_pkg::word_t      lp_wdata_i,
  output logic                  lp_done_o,
  output fetch_pkg::word_t      lp_rdata_o
);
  import fetch_pkg::*;

  // ------------------------------
  // fetch stage <-> prefetch
  // ------------------------------
  logic  branch, fetch_valid, fetch_ready;
  addr_t branch_addr, fetch_addr;
  word_t fetch_rdata;

  // wishbone links
  logic  if_cyc, if_stb, if_ack;           // prefetch, master m1
  addr_t if_adr;
  word_t if_dat_r;
  logic  lp_cyc, lp_stb, lp_we, lp_ack;    // load port, master m0
  addr_t lp_adr;
  word_t lp_dat_w, lp_dat_r;
  logic  s_cyc, s_stb, s_we, s_ack;        // arbiter to memory
  addr_t s_adr;
  word_t s_dat_w, s_dat_r;

  if_stage if_stage_inst (
    .clk, .rst_n,
    .boot_addr_i, .dm_halt_addr_i, .dm_exception_addr_i, .mepc_i, .depc_i,
    .jump_target_id_i, .jump_target_ex_i, .trap_base_i, .irq_id_i,
    .pc_set_i, .pc_sel_i, .exc_sel_i,
    .req_i, .halt_if_i, .id_ready_i, .clear_instr_valid_i,
    .fetch_valid_i (fetch_valid),
    .fetch_rdata_i (fetch_rdata),
    .fetch_addr_i  (fetch_addr),
    .fetch_ready_o (fetch_ready),
    .branch_o      (branch),
    .branch_addr_o (branch_addr),
    .instr_valid_id_o, .instr_rdata_id_o, .pc_id_o, .pc_if_o,
    .csr_mtvec_init_o, .perf_imiss_o
  );

  prefetch_buffer #(.FIFO_DEPTH(FIFO_DEPTH)) prefetch_buffer_inst (
    .clk, .rst_n, .req_i,
    .branch_i      (branch),
    .branch_addr_i (branch_addr),
    .fetch_ready_i (fetch_ready),
    .fetch_valid_o (fetch_valid),
    .fetch_rdata_o (fetch_rdata),
    .fetch_addr_o  (fetch_addr),
    .wb_cyc_o      (if_cyc),
    .wb_stb_o      (if_stb),
    .wb_adr_o      (if_adr),
    .wb_dat_i      (if_dat_r),
    .wb_ack_i      (if_ack),
    .busy_o        (if_busy_o)
  );

  load_port load_port_inst (
    .clk, .rst_n,
    .req_i    (lp_req_i),
    .we_i     (lp_we_i),
    .addr_i   (lp_addr_i),
    .wdata_i  (lp_wdata_i),
    .done_o   (lp_done_o),
    .rdata_o  (lp_rdata_o),
    .wb_cyc_o (lp_cyc),
    .wb_stb_o (lp_stb),
    .wb_we_o  (lp_we),
    .wb_adr_o (lp_adr),
    .wb_dat_o (lp_dat_w),
    .wb_dat_i (lp_dat_r),
    .wb_ack_i (lp_ack)
  );

  wb_arbiter wb_arbiter_inst (
    .clk, .rst_n,
    .m0_cyc_i (lp_cyc), .m0_stb_i (lp_stb), .m0_we_i (lp_we),
    .m0_adr_i (lp_adr), .m0_dat_i (lp_dat_w), .m0_dat_o (lp_dat_r), .m0_ack_o (lp_ack),
    .m1_cyc_i (if_cyc), .m1_stb_i (if_stb), .m1_we_i (1'b0),      // fetch only reads
    .m1_adr_i (if_adr), .m1_dat_i ('0), .m1_dat_o (if_dat_r), .m1_ack_o (if_ack),
    .s_cyc_o (s_cyc), .s_stb_o (s_stb), .s_we_o (s_we), .s_adr_o (s_adr),
    .s_dat_o (s_dat_w), .s_dat_i (s_dat_r), .s_ack_i (s_ack)
  );

  wb_sram #(.MEM_WORDS(MEM_WORDS)) wb_sram_inst (
    .clk, .rst_n,
    .wb_cyc_i (s_cyc),
    .wb_stb_i (s_stb),
    .wb_we_i  (s_we),
    .wb_adr_i (s_adr),
    .wb_dat_i (s_dat_w),
    .wb_dat_o (s_dat_r),
    .wb_ack_o (s_ack)
  );

endmodule

// ==== bench/fetch_checker.sv ====
// testbench checker: models the memory and the expected pc stream and compares DUT outputs per cycle
`timescale 1ns/1ns
module fetch_checker #(
  parameter int MEM_WORDS = fetch_pkg::MEM_WORDS_DEF
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  fetch_pkg::addr_t      boot_addr_i,
  input  fetch_pkg::addr_t      dm_halt_addr_i,
  input  fetch_pkg::addr_t      dm_exception_addr_i,
  input  fetch_pkg::addr_t      mepc_i,
  input  fetch_pkg::addr_t      depc_i,
  input  fetch_pkg::addr_t      jump_target_id_i,
  input  fetch_pkg::addr_t      jump_target_ex_i,
  input  fetch_pkg::trap_base_t trap_base_i,
  input  fetch_pkg::irq_id_t    irq_id_i,
  input  logic                  pc_set_i,
  input  fetch_pkg::pc_sel_e    pc_sel_i,
  input  fetch_pkg::exc_sel_e   exc_sel_i,
  input  logic                  req_i,
  input  logic                  halt_if_i,
  input  logic                  id_ready_i,
  input  logic                  clear_instr_valid_i,
  input  logic                  instr_valid_id_o,  // DUT outputs, watched
  input  fetch_pkg::word_t      instr_rdata_id_o,
  input  fetch_pkg::addr_t      pc_id_o,
  input  fetch_pkg::addr_t      pc_if_o,
  input  logic                  csr_mtvec_init_o,
  input  logic                  perf_imiss_o,
  input  logic                  if_busy_o,
  input  logic                  lp_req_i,
  input  logic                  lp_we_i,
  input  fetch_pkg::addr_t      lp_addr_i,
  input  fetch_pkg::word_t      lp_wdata_i,
  input  logic                  lp_done_o,
  input  fetch_pkg::word_t      lp_rdata_o,
  output int                    err_cnt_o,
  output int                    chk_cnt_o,
  output int                    acc_cnt_o          // instructions accepted so far
);
  import fetch_pkg::*;

  word_t mem_m [MEM_WORDS];  // image written through the load port
  addr_t exp_pc;             // pc of the next instruction to accept
  addr_t last_pc;            // fence.i restarts after this one
  addr_t chk_pc, hold_pc;
  word_t hold_dat;
  logic  acc_q, started, exp_valid;
  logic  lp_pend, lp_we_q;   // load-port transfer in flight
  addr_t lp_adr_q;
  word_t lp_dat_q;
  logic  rst_seen = 1'b0;    // one reset edge already passed

  function automatic int widx(input addr_t a);
    return int'((a >> 2) % MEM_WORDS);
  endfunction

  task automatic check(input logic ok, input string msg);
    chk_cnt_o++;
    if (!ok) begin
      err_cnt_o++;
      $display("FAILED %0t: %s", $time, msg);
    end
  endtask

  // ------------------------------
  // reference redirect rules
  // ------------------------------
  function automatic addr_t redirect_target();
    addr_t t;
    case (pc_sel_i)
      PC_BOOT:      t = {boot_addr_i[31:2], 2'b00};
      PC_JUMP:      t = jump_target_id_i;
      PC_BRANCH:    t = jump_target_ex_i;
      PC_MRET:      t = mepc_i;
      PC_DRET:      t = depc_i;
      PC_FENCEI:    t = last_pc + 32'd4;  // word after the fence
      PC_EXCEPTION: begin
        case (exc_sel_i)
          EXC_PC_IRQ: t = {trap_base_i, 1'b0, irq_id_i, 2'b00};
          EXC_PC_DBD: t = {dm_halt_addr_i[31:2], 2'b00};
          EXC_PC_DBE: t = {dm_exception_addr_i[31:2], 2'b00};
          default:    t = {trap_base_i, 8'h00};
        endcase
      end
      default:      t = 'x;
    endcase
    return t;
  endfunction

  always @(posedge clk) begin
    if (!rst_n) begin
      if (rst_seen) begin  // outputs settle by the second reset edge
        check(instr_valid_id_o === 1'b0 && pc_id_o === '0 && if_busy_o === 1'b0 &&
              lp_done_o === 1'b0 && csr_mtvec_init_o === 1'b0, "outputs not cleared by reset");
      end
      rst_seen  = 1'b1;
      acc_q     = 1'b0;
      started   = 1'b0;
      exp_valid = 1'b0;
      lp_pend   = 1'b0;
      exp_pc    = '0;
      last_pc   = '0;
    end else begin
      // outcome of the previous edge
      if (acc_q) begin
        check(pc_id_o === chk_pc, $sformatf("pc_id_o %h, expected %h", pc_id_o, chk_pc));
        check(instr_rdata_id_o === mem_m[widx(chk_pc)],
              $sformatf("instr at %h is %h, expected %h", chk_pc, instr_rdata_id_o,
                        mem_m[widx(chk_pc)]));
      end else if (started) begin
        check(pc_id_o === hold_pc && instr_rdata_id_o === hold_dat,
              $sformatf("IF/ID changed while stalled, pc %h", pc_id_o));
      end
      check(instr_valid_id_o === exp_valid, $sformatf("instr_valid_id_o %b, expected %b",
            instr_valid_id_o, exp_valid));
      check(csr_mtvec_init_o === (pc_set_i && pc_sel_i == PC_BOOT), "csr_mtvec_init_o wrong");
      // load port, done first so a back-to-back request is not lost
      if (lp_done_o) begin
        if (!lp_pend) check(1'b0, "done_o without a request");
        else if (lp_we_q) mem_m[widx(lp_adr_q)] = lp_dat_q;
        else check(lp_rdata_o === mem_m[widx(lp_adr_q)],
                   $sformatf("load read %h gave %h", lp_adr_q, lp_rdata_o));
        lp_pend = 1'b0;
      end
      if (lp_req_i && !lp_pend) begin
        lp_pend  = 1'b1;
        lp_we_q  = lp_we_i;
        lp_adr_q = lp_addr_i;
        lp_dat_q = lp_wdata_i;
      end
      // what this edge does to IF/ID
      hold_pc  = pc_id_o;
      hold_dat = instr_rdata_id_o;
      acc_q    = 1'b0;
      if (pc_set_i) begin
        exp_pc = redirect_target();
      end else if (!perf_imiss_o && req_i && id_ready_i && !halt_if_i) begin
        check(pc_if_o === exp_pc, $sformatf("head pc %h, expected %h", pc_if_o, exp_pc));
        acc_q   = 1'b1;
        chk_pc  = exp_pc;
        last_pc = exp_pc;
        exp_pc  = exp_pc + 32'd4;  // sequential, no gaps
        started = 1'b1;
        acc_cnt_o++;
      end
      exp_valid = acc_q ? 1'b1 : (clear_instr_valid_i ? 1'b0 : instr_valid_id_o);
    end
  end

endmodule

// ==== bench/tb_fetch.sv ====
// testbench top for the fetch subsystem: loads a program, then walks a table of redirects and stalls
`timescale 1ns/1ns
module tb_fetch;
  import fetch_pkg::*;

  localparam int NSTEPS     = 14;
  localparam int PROG_WORDS = 64;
  localparam int LIMIT      = 400 * NSTEPS + 2000;  // cycle budget for the whole run

  // one row of the stimulus table
  typedef struct packed {
    pc_sel_e    kind;   // redirect source
    exc_sel_e   exc;
    irq_id_t    irq;
    addr_t      addr;   // operand for the chosen source
    logic [7:0] n;      // instructions to accept
    logic [1:0] stall;  // bit0 random id_ready, bit1 random halt
    logic       clr;    // random clear_instr_valid pulses
    logic       lp;     // load-port reads alongside fetch
  } step_t;

  logic       clk, rst_n;
  addr_t      boot_addr_i, dm_halt_addr_i, dm_exception_addr_i, mepc_i, depc_i;
  addr_t      jump_target_id_i, jump_target_ex_i;
  trap_base_t trap_base_i;
  irq_id_t    irq_id_i;
  logic       pc_set_i;
  pc_sel_e    pc_sel_i;
  exc_sel_e   exc_sel_i;
  logic       req_i, halt_if_i, id_ready_i, clear_instr_valid_i;
  logic       instr_valid_id_o, csr_mtvec_init_o, perf_imiss_o, if_busy_o;
  word_t      instr_rdata_id_o;
  addr_t      pc_id_o, pc_if_o;
  logic       lp_req_i, lp_we_i, lp_done_o;
  addr_t      lp_addr_i;
  word_t      lp_wdata_i, lp_rdata_o;
  int         err_cnt, chk_cnt, acc_cnt;  // from the checker
  int         cycles;
  logic [15:0] lfsr;
  step_t      steps [NSTEPS];

  fetch_top #(.FIFO_DEPTH(FIFO_DEPTH_DEF), .MEM_WORDS(MEM_WORDS_DEF)) fetch_top_inst (.*);

  fetch_checker #(.MEM_WORDS(MEM_WORDS_DEF)) fetch_checker_inst (
    .*,
    .err_cnt_o (err_cnt),
    .chk_cnt_o (chk_cnt),
    .acc_cnt_o (acc_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // ------------------------------
  // helpers
  // ------------------------------
  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);  // one step per bit
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;  // inputs change just after the edge
  endtask

  // one load-port transfer, returns after done_o
  task automatic lp_access(input logic we, input addr_t a, input word_t d);
    lp_req_i   = 1'b1;
    lp_we_i    = we;
    lp_addr_i  = a;
    lp_wdata_i = d;
    next_cycle();
    lp_req_i = 1'b0;
    while (!lp_done_o) next_cycle();
  endtask

  // redirect, then accept s.n instructions under the row's stall pattern
  task automatic run_step(input step_t s);
    logic [31:0] r;
    addr_t       rd_addr [3];
    int          goal;
    case (s.kind)
      PC_BOOT:      boot_addr_i      = s.addr;
      PC_JUMP:      jump_target_id_i = s.addr;
      PC_BRANCH:    jump_target_ex_i = s.addr;
      PC_MRET:      mepc_i           = s.addr;
      PC_DRET:      depc_i           = s.addr;
      PC_EXCEPTION: begin
        trap_base_i = s.addr[31:8];
        if (s.exc == EXC_PC_DBD) dm_halt_addr_i = s.addr;
        if (s.exc == EXC_PC_DBE) dm_exception_addr_i = s.addr;
      end
      default: ;  // fence.i needs no operand
    endcase
    irq_id_i  = s.irq;
    exc_sel_i = s.exc;
    pc_sel_i  = s.kind;
    pc_set_i  = 1'b1;
    for (int i = 0; i < 3; i++) begin
      take_bits(6, r);  // drawn up front, keeps the lfsr order fixed
      rd_addr[i] = {24'h0, r[5:0], 2'b00};
    end
    next_cycle();
    pc_set_i = 1'b0;
    goal     = acc_cnt + s.n;
    fork
      begin
        while (acc_cnt < goal) begin
          take_bits(3, r);
          id_ready_i          = !(s.stall[0] && r[0]);
          halt_if_i           = s.stall[1] && r[1];
          clear_instr_valid_i = s.clr && r[2];
          next_cycle();
        end
        id_ready_i          = 1'b0;  // park decode between rows
        halt_if_i           = 1'b0;
        clear_instr_valid_i = 1'b0;
      end
      begin
        if (s.lp) begin
          for (int i = 0; i < 3; i++) lp_access(1'b0, rd_addr[i], '0);
        end
      end
    join
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    logic [31:0] r;
    lfsr  = 16'd14060;
    rst_n = 1'b0;
    boot_addr_i         = 32'h0000_0000;
    dm_halt_addr_i      = 32'h0000_00e0;  // decoys until a row picks them
    dm_exception_addr_i = 32'h0000_00e8;
    mepc_i              = 32'h0000_00d0;
    depc_i              = 32'h0000_00d8;
    jump_target_id_i    = 32'h0000_00c8;
    jump_target_ex_i    = 32'h0000_00cc;
    trap_base_i = '0;
    irq_id_i    = '0;
    pc_set_i    = 1'b0;
    pc_sel_i    = PC_BOOT;
    exc_sel_i   = EXC_PC_EXCEPTION;
    req_i       = 1'b0;
    halt_if_i   = 1'b0;
    id_ready_i  = 1'b0;
    clear_instr_valid_i = 1'b0;
    lp_req_i    = 1'b0;
    lp_we_i     = 1'b0;
    lp_addr_i   = '0;
    lp_wdata_i  = '0;
    // kind, exc, irq, operand, n, stall, clr, lp
    // trap bases above the memory size alias back onto the program image
    steps[0]  = '{PC_BOOT,      EXC_PC_EXCEPTION, 5'd0,  32'h43,  8'd12, 2'b00, 1'b0, 1'b0};
    steps[1]  = '{PC_JUMP,      EXC_PC_EXCEPTION, 5'd0,  32'h08,  8'd6,  2'b01, 1'b0, 1'b0};
    steps[2]  = '{PC_BRANCH,    EXC_PC_EXCEPTION, 5'd0,  32'h60,  8'd6,  2'b10, 1'b0, 1'b0};
    steps[3]  = '{PC_MRET,      EXC_PC_EXCEPTION, 5'd0,  32'h20,  8'd5,  2'b01, 1'b1, 1'b0};
    steps[4]  = '{PC_DRET,      EXC_PC_EXCEPTION, 5'd0,  32'h90,  8'd5,  2'b00, 1'b0, 1'b1};
    steps[5]  = '{PC_FENCEI,    EXC_PC_EXCEPTION, 5'd0,  32'h00,  8'd6,  2'b11, 1'b1, 1'b0};
    steps[6]  = '{PC_EXCEPTION, EXC_PC_EXCEPTION, 5'd0,  32'h400, 8'd4,  2'b00, 1'b0, 1'b0};
    steps[7]  = '{PC_EXCEPTION, EXC_PC_IRQ,       5'd3,  32'h00,  8'd4,  2'b00, 1'b0, 1'b0};
    steps[8]  = '{PC_EXCEPTION, EXC_PC_IRQ,       5'd17, 32'h800, 8'd4,  2'b01, 1'b0, 1'b0};
    steps[9]  = '{PC_EXCEPTION, EXC_PC_IRQ,       5'd31, 32'hc00, 8'd4,  2'b00, 1'b0, 1'b1};
    steps[10] = '{PC_EXCEPTION, EXC_PC_DBD,       5'd0,  32'ha2,  8'd4,  2'b00, 1'b0, 1'b0};
    steps[11] = '{PC_EXCEPTION, EXC_PC_DBE,       5'd0,  32'hb7,  8'd4,  2'b10, 1'b0, 1'b0};
    steps[12] = '{PC_BOOT,      EXC_PC_EXCEPTION, 5'd0,  32'h01,  8'd16, 2'b11, 1'b1, 1'b1};
    steps[13] = '{PC_BRANCH,    EXC_PC_EXCEPTION, 5'd0,  32'hc0,  8'd8,  2'b01, 1'b0, 1'b1};
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < PROG_WORDS; i++) begin
      take_bits(32, r);
      lp_access(1'b1, addr_t'(i * 4), r);  // program image
    end
    for (int i = 0; i < PROG_WORDS; i++) lp_access(1'b0, addr_t'(i * 4), '0);
    req_i = 1'b1;
    for (int i = 0; i < NSTEPS; i++) run_step(steps[i]);
    repeat (4) next_cycle();
    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // hang guard
  initial begin
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, run did not end within %0d cycles", LIMIT);
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== filelist.f ====
common/fetch_pkg.sv
fetch/if_stage.sv
fetch/prefetch_buffer.sv
logic/wb_arbiter.sv
logic/load_port.sv
logic/wb_sram.sv
logic/fetch_top.sv
bench/fetch_checker.sv
bench/tb_fetch.sv
